/* hw/mmu_defines.svh */
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// joint TLB geometry
`define TLB_ENTRIES 16
`define TLB_IDX_W   4

// entry field widths
`define VPN2_W 19
`define PFN_W  20
`define ASID_W 8

// CP0 register numbers
`define CP0_INDEX    5'd0
`define CP0_RANDOM   5'd1
`define CP0_ENTRYLO0 5'd2
`define CP0_ENTRYLO1 5'd3
`define CP0_ENTRYHI  5'd10

// unmapped kernel segments, 512 MB each
`define KSEG0_BASE 32'h8000_0000
`define KSEG1_BASE 32'hA000_0000

// c field value of a cacheable page
`define CACHED_ATTR 3'd3

`endif

/* hw/mmu_pkg.sv */
`include "mmu_defines.svh"

package mmu_pkg;

    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;

    // one page of an even/odd pair
    typedef struct packed {
        logic [`PFN_W-1:0] pfn;
        logic [2:0]        c;
        logic              d;
        logic              v;
    } tlb_page_t;

    typedef struct packed {
        logic [`VPN2_W-1:0] vpn2;
        logic [`ASID_W-1:0] asid;
        logic               g;
        tlb_page_t          even;
        tlb_page_t          odd;
    } tlb_entry_t;

    typedef struct packed {
        logic [31:0] vaddr;
        logic        is_store;
    } xlate_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        miss;
        logic        invalid;
        logic        modified;
        logic        uncached;
    } xlate_rsp_t;

    // tlbp, tlbr, tlbwi, tlbwr
    typedef enum logic [1:0] {
        probe,
        read,
        write_indexed,
        write_random
    } tlb_cmd_e;

    typedef struct packed {
        logic [`VPN2_W-1:0]            vpn2;
        logic [31-`VPN2_W-`ASID_W:0]   zero;
        logic [`ASID_W-1:0]            asid;
    } entry_hi_t;

    typedef struct packed {
        logic [31-`PFN_W-6:0] zero;
        logic [`PFN_W-1:0]    pfn;
        logic [2:0]           c;
        logic                 d;
        logic                 v;
        logic                 g;
    } entry_lo_t;

    // same CP0 data word, seen as EntryHi or as EntryLo
    typedef union packed {
        entry_hi_t hi;
        entry_lo_t lo;
    } cp0_word_u;

    typedef struct packed {
        logic       valid;
        logic [4:0] addr;
        cp0_word_u  data;
    } cp0_wr_t;

endpackage

/* hw/tlb_match.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tlb_match (
    input  logic                                   aclk,
    input  logic                                   rst,
    input  mmu_pkg::tlb_entry_t [`TLB_ENTRIES-1:0] entries,
    input  logic [`VPN2_W-1:0]                     vpn2,
    input  logic [`ASID_W-1:0]                     asid,
    output logic                                   hit,
    output logic [`TLB_IDX_W-1:0]                  hit_idx
);
    import mmu_pkg::*;

    logic [`TLB_ENTRIES-1:0] match;
    logic [`TLB_ENTRIES-1:0] live_match;

    // every entry compared at once, global entries ignore asid
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = (entries[i].vpn2 == vpn2) &&
                       (entries[i].g || (entries[i].asid == asid));
            live_match[i] = match[i] && (entries[i].even.v || entries[i].odd.v);
        end
    end

    assign hit = |match;

    // lowest index wins when cleared entries overlap
    always_comb begin
        hit_idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    // two entries with valid pages for one address is a software error
    a_single_live_match: assert property (
        @(posedge aclk) disable iff (rst) $countones(live_match) <= 1
    ) else $error("tlb_match: %0d live entries match vpn2 %h asid %h",
                  $countones(live_match), vpn2, asid);

endmodule

/* hw/tlb_entry_array.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tlb_entry_array (
    input  logic                                   aclk,
    input  logic                                   rst,
    // write port, driven by tlbwi and tlbwr
    input  logic                                   wr_en,
    input  logic [`TLB_IDX_W-1:0]                  wr_idx,
    input  mmu_pkg::tlb_entry_t                    wr_entry,
    // indexed read for tlbr
    input  logic [`TLB_IDX_W-1:0]                  rd_idx,
    output mmu_pkg::tlb_entry_t                    rd_entry,
    // whole array for the associative searches
    output mmu_pkg::tlb_entry_t [`TLB_ENTRIES-1:0] entries
);

    // entries come up with v and g clear
    always_ff @(posedge aclk) begin
        if (rst) begin
            entries <= '0;
        end else if (wr_en) begin
            entries[wr_idx] <= wr_entry;
        end
    end

    // read is combinational, a write shows up one edge later
    assign rd_entry = entries[rd_idx];

endmodule

/* hw/mmu_cp0.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

module mmu_cp0 (
    input  logic                                   aclk,
    input  logic                                   rst,
    // software register access
    input  mmu_pkg::cp0_wr_t                       cp0_wr,
    input  logic [4:0]                             cp0_raddr,
    output logic [31:0]                            cp0_rdata,
    // TLB instructions
    input  logic                                   cmd_valid,
    input  mmu_pkg::tlb_cmd_e                      cmd_op,
    output logic                                   cmd_ready,
    // entry array side
    input  mmu_pkg::tlb_entry_t [`TLB_ENTRIES-1:0] entries,
    output logic [`TLB_IDX_W-1:0]                  rd_idx,
    input  mmu_pkg::tlb_entry_t                    rd_entry,
    output logic                                   wr_en,
    output logic [`TLB_IDX_W-1:0]                  wr_idx,
    output mmu_pkg::tlb_entry_t                    wr_entry,
    // current address space for the lookups
    output logic [`ASID_W-1:0]                     asid
);
    import mmu_pkg::*;

    logic      ready_q;
    logic      probe_fail_q;
    tlb_idx_t  index_q;
    tlb_idx_t  random_q;
    entry_hi_t entry_hi_q;
    entry_lo_t entry_lo0_q;
    entry_lo_t entry_lo1_q;

    entry_hi_t wr_hi;
    entry_lo_t wr_lo;
    logic      cmd_fire;
    logic      probe_hit;
    tlb_idx_t  probe_idx;

    assign cmd_ready = ready_q;
    assign cmd_fire  = cmd_valid && ready_q;
    assign asid      = entry_hi_q.asid;

    // decode the write word both ways, reserved bits forced to zero
    always_comb begin
        wr_hi      = cp0_wr.data.hi;
        wr_hi.zero = '0;
        wr_lo      = cp0_wr.data.lo;
        wr_lo.zero = '0;
    end

    // tlbp searches with EntryHi
    tlb_match i_probe_match (
        .aclk    (aclk),
        .rst     (rst),
        .entries (entries),
        .vpn2    (entry_hi_q.vpn2),
        .asid    (entry_hi_q.asid),
        .hit     (probe_hit),
        .hit_idx (probe_idx)
    );

    assign rd_idx = index_q;
    assign wr_en  = cmd_fire && (cmd_op == write_indexed || cmd_op == write_random);
    assign wr_idx = (cmd_op == write_random) ? random_q : index_q;

    // entry image built from EntryHi and the two EntryLo registers
    always_comb begin
        wr_entry.vpn2      = entry_hi_q.vpn2;
        wr_entry.asid      = entry_hi_q.asid;
        wr_entry.g         = entry_lo0_q.g & entry_lo1_q.g;
        wr_entry.even.pfn  = entry_lo0_q.pfn;
        wr_entry.even.c    = entry_lo0_q.c;
        wr_entry.even.d    = entry_lo0_q.d;
        wr_entry.even.v    = entry_lo0_q.v;
        wr_entry.odd.pfn   = entry_lo1_q.pfn;
        wr_entry.odd.c     = entry_lo1_q.c;
        wr_entry.odd.d     = entry_lo1_q.d;
        wr_entry.odd.v     = entry_lo1_q.v;
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            ready_q      <= 1'b0;
            probe_fail_q <= 1'b0;
            index_q      <= '0;
            random_q     <= tlb_idx_t'(`TLB_ENTRIES - 1);
            entry_hi_q   <= '0;
            entry_lo0_q  <= '0;
            entry_lo1_q  <= '0;
        end else begin
            ready_q <= 1'b1;
            // Random and unknown numbers are read only
            if (cp0_wr.valid) begin
                case (cp0_wr.addr)
                    `CP0_INDEX:    index_q     <= cp0_wr.data[`TLB_IDX_W-1:0];
                    `CP0_ENTRYLO0: entry_lo0_q <= wr_lo;
                    `CP0_ENTRYLO1: entry_lo1_q <= wr_lo;
                    `CP0_ENTRYHI:  entry_hi_q  <= wr_hi;
                    default: ;
                endcase
            end
            // command results take priority over a same-cycle software write
            if (cmd_fire) begin
                case (cmd_op)
                    probe: begin
                        probe_fail_q <= !probe_hit;
                        if (probe_hit) begin
                            index_q <= probe_idx;
                        end
                    end
                    read: begin
                        entry_hi_q  <= '{vpn2: rd_entry.vpn2, zero: '0, asid: rd_entry.asid};
                        entry_lo0_q <= '{zero: '0, pfn: rd_entry.even.pfn, c: rd_entry.even.c,
                                         d: rd_entry.even.d, v: rd_entry.even.v, g: rd_entry.g};
                        entry_lo1_q <= '{zero: '0, pfn: rd_entry.odd.pfn, c: rd_entry.odd.c,
                                         d: rd_entry.odd.d, v: rd_entry.odd.v, g: rd_entry.g};
                    end
                    // wraps from 0 back to the top entry
                    write_random: random_q <= random_q - 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (cp0_raddr)
            `CP0_INDEX:    cp0_rdata = {probe_fail_q, {(31-`TLB_IDX_W){1'b0}}, index_q};
            `CP0_RANDOM:   cp0_rdata = {{(32-`TLB_IDX_W){1'b0}}, random_q};
            `CP0_ENTRYLO0: cp0_rdata = entry_lo0_q;
            `CP0_ENTRYLO1: cp0_rdata = entry_lo1_q;
            `CP0_ENTRYHI:  cp0_rdata = entry_hi_q;
            default:       cp0_rdata = '0;
        endcase
    end

    a_cmd_op_known: assert property (
        @(posedge aclk) disable iff (rst) cmd_valid |-> !$isunknown(cmd_op)
    ) else $error("mmu_cp0: cmd_op unknown while cmd_valid is high");

endmodule

/* hw/tlb_translate.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tlb_translate #(
    // only the data port reports modified
    parameter bit CHECK_DIRTY = 1'b1
) (
    input  logic                                   aclk,
    input  logic                                   rst,
    input  logic                                   req_valid,
    input  mmu_pkg::xlate_req_t                    req,
    output logic                                   req_ready,
    output logic                                   rsp_valid,
    output mmu_pkg::xlate_rsp_t                    rsp,
    input  logic                                   rsp_ready,
    input  mmu_pkg::tlb_entry_t [`TLB_ENTRIES-1:0] entries,
    input  logic [`ASID_W-1:0]                     asid
);
    import mmu_pkg::*;

    localparam logic [31:0] kseg0_base = `KSEG0_BASE;
    localparam logic [31:0] kseg1_base = `KSEG1_BASE;

    logic       in_kseg0;
    logic       in_kseg1;
    logic       hit;
    tlb_idx_t   hit_idx;
    tlb_page_t  page;
    xlate_rsp_t rsp_next;
    logic       accept;

    // segment picked by the top three address bits
    assign in_kseg0 = req.vaddr[31:29] == kseg0_base[31:29];
    assign in_kseg1 = req.vaddr[31:29] == kseg1_base[31:29];

    tlb_match i_match (
        .aclk    (aclk),
        .rst     (rst),
        .entries (entries),
        .vpn2    (req.vaddr[31:13]),
        .asid    (asid),
        .hit     (hit),
        .hit_idx (hit_idx)
    );

    // bit 12 chooses the odd page
    assign page = req.vaddr[12] ? entries[hit_idx].odd : entries[hit_idx].even;

    always_comb begin
        rsp_next = '0;
        if (in_kseg0) begin
            rsp_next.paddr = req.vaddr - kseg0_base;
        end else if (in_kseg1) begin
            rsp_next.paddr    = req.vaddr - kseg1_base;
            rsp_next.uncached = 1'b1;
        end else if (!hit) begin
            rsp_next.miss = 1'b1;
        end else begin
            rsp_next.paddr    = {page.pfn, req.vaddr[11:0]};
            rsp_next.invalid  = !page.v;
            rsp_next.modified = CHECK_DIRTY && req.is_store && page.v && !page.d;
            rsp_next.uncached = page.c != `CACHED_ATTR;
        end
    end

    // one-entry output stage, refills while the old response drains
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (req_ready) begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            rsp <= rsp_next;
        end
    end

    a_rsp_hold: assert property (
        @(posedge aclk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    ) else $error("tlb_translate: response changed under back-pressure");

endmodule

/* hw/tlb_mmu_top.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tlb_mmu_top (
    input  logic                aclk,
    input  logic                rst,
    // CP0 register access
    input  mmu_pkg::cp0_wr_t    cp0_wr,
    input  logic [4:0]          cp0_raddr,
    output logic [31:0]         cp0_rdata,
    // TLB instructions
    input  logic                cmd_valid,
    input  mmu_pkg::tlb_cmd_e   cmd_op,
    output logic                cmd_ready,
    // instruction fetch port
    input  logic                ifetch_req_valid,
    input  mmu_pkg::xlate_req_t ifetch_req,
    output logic                ifetch_req_ready,
    output logic                ifetch_rsp_valid,
    output mmu_pkg::xlate_rsp_t ifetch_rsp,
    input  logic                ifetch_rsp_ready,
    // data access port
    input  logic                data_req_valid,
    input  mmu_pkg::xlate_req_t data_req,
    output logic                data_req_ready,
    output logic                data_rsp_valid,
    output mmu_pkg::xlate_rsp_t data_rsp,
    input  logic                data_rsp_ready
);
    import mmu_pkg::*;

    tlb_entry_t [`TLB_ENTRIES-1:0] entries;
    tlb_entry_t                    rd_entry;
    tlb_entry_t                    wr_entry;
    tlb_idx_t                      rd_idx;
    tlb_idx_t                      wr_idx;
    logic                          wr_en;
    logic [`ASID_W-1:0]            asid;

    tlb_entry_array i_entry_array (
        .aclk     (aclk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_entry (wr_entry),
        .rd_idx   (rd_idx),
        .rd_entry (rd_entry),
        .entries  (entries)
    );

    mmu_cp0 i_cp0 (
        .aclk      (aclk),
        .rst       (rst),
        .cp0_wr    (cp0_wr),
        .cp0_raddr (cp0_raddr),
        .cp0_rdata (cp0_rdata),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_ready (cmd_ready),
        .entries   (entries),
        .rd_idx    (rd_idx),
        .rd_entry  (rd_entry),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_entry  (wr_entry),
        .asid      (asid)
    );

    tlb_translate #(
        .CHECK_DIRTY (1'b0)
    ) i_ifetch_xlate (
        .aclk      (aclk),
        .rst       (rst),
        .req_valid (ifetch_req_valid),
        .req       (ifetch_req),
        .req_ready (ifetch_req_ready),
        .rsp_valid (ifetch_rsp_valid),
        .rsp       (ifetch_rsp),
        .rsp_ready (ifetch_rsp_ready),
        .entries   (entries),
        .asid      (asid)
    );

    tlb_translate #(
        .CHECK_DIRTY (1'b1)
    ) i_data_xlate (
        .aclk      (aclk),
        .rst       (rst),
        .req_valid (data_req_valid),
        .req       (data_req),
        .req_ready (data_req_ready),
        .rsp_valid (data_rsp_valid),
        .rsp       (data_rsp),
        .rsp_ready (data_rsp_ready),
        .entries   (entries),
        .asid      (asid)
    );

endmodule

/* sim/tlb_mmu_model.svh */
`ifndef TLB_MMU_MODEL_SVH
`define TLB_MMU_MODEL_SVH

// mirror of the TLB entries and the CP0 MMU registers
tlb_entry_t tlb_model [`TLB_ENTRIES];
logic       probe_fail_m;
tlb_idx_t   index_m;
tlb_idx_t   random_m;
entry_hi_t  hi_m;
entry_lo_t  lo0_m;
entry_lo_t  lo1_m;

function automatic void reset_model();
    foreach (tlb_model[i]) begin
        tlb_model[i] = '0;
    end
    probe_fail_m = 1'b0;
    index_m      = '0;
    random_m     = tlb_idx_t'(`TLB_ENTRIES - 1);
    hi_m         = '0;
    lo0_m        = '0;
    lo1_m        = '0;
endfunction

// lowest matching index, -1 when nothing matches
function automatic int find_match(logic [`VPN2_W-1:0] vpn2, logic [`ASID_W-1:0] asid);
    int hit;
    hit = -1;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
        if (hit < 0 && tlb_model[i].vpn2 == vpn2 &&
            (tlb_model[i].g || tlb_model[i].asid == asid)) begin
            hit = i;
        end
    end
    return hit;
endfunction

// pool value not held by any other entry, so a write never adds a second match
function automatic logic [`VPN2_W-1:0] free_vpn2(int target);
    logic [`VPN2_W-1:0] cand;
    bit                 taken;
    do begin
        cand  = 19'h10 + 19'(next_random() % 32);
        taken = 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (i != target && tlb_model[i].vpn2 == cand) begin
                taken = 1'b1;
            end
        end
    end while (taken);
    return cand;
endfunction

function automatic void apply_cp0_write(logic [4:0] reg_num, cp0_word_u word);
    case (reg_num)
        `CP0_INDEX: index_m = word[`TLB_IDX_W-1:0];
        `CP0_ENTRYLO0: begin
            lo0_m      = word.lo;
            lo0_m.zero = '0;
        end
        `CP0_ENTRYLO1: begin
            lo1_m      = word.lo;
            lo1_m.zero = '0;
        end
        `CP0_ENTRYHI: begin
            hi_m      = word.hi;
            hi_m.zero = '0;
        end
        default: ;
    endcase
endfunction

function automatic logic [31:0] expected_cp0_read(logic [4:0] reg_num);
    case (reg_num)
        `CP0_INDEX:    return {probe_fail_m, {(31-`TLB_IDX_W){1'b0}}, index_m};
        `CP0_RANDOM:   return {{(32-`TLB_IDX_W){1'b0}}, random_m};
        `CP0_ENTRYLO0: return lo0_m;
        `CP0_ENTRYLO1: return lo1_m;
        `CP0_ENTRYHI:  return hi_m;
        default:       return '0;
    endcase
endfunction

// g of a written entry is the AND of both EntryLo g bits
function automatic tlb_entry_t entry_from_regs();
    tlb_entry_t e;
    e.vpn2 = hi_m.vpn2;
    e.asid = hi_m.asid;
    e.g    = lo0_m.g & lo1_m.g;
    e.even = '{pfn: lo0_m.pfn, c: lo0_m.c, d: lo0_m.d, v: lo0_m.v};
    e.odd  = '{pfn: lo1_m.pfn, c: lo1_m.c, d: lo1_m.d, v: lo1_m.v};
    return e;
endfunction

function automatic void apply_cmd(tlb_cmd_e op);
    tlb_entry_t e;
    int         hit;
    case (op)
        probe: begin
            hit          = find_match(hi_m.vpn2, hi_m.asid);
            probe_fail_m = (hit < 0);
            if (hit >= 0) begin
                index_m = tlb_idx_t'(hit);
            end
        end
        read: begin
            e     = tlb_model[index_m];
            hi_m  = '{vpn2: e.vpn2, zero: '0, asid: e.asid};
            lo0_m = '{zero: '0, pfn: e.even.pfn, c: e.even.c, d: e.even.d,
                      v: e.even.v, g: e.g};
            lo1_m = '{zero: '0, pfn: e.odd.pfn, c: e.odd.c, d: e.odd.d,
                      v: e.odd.v, g: e.g};
        end
        write_indexed: tlb_model[index_m] = entry_from_regs();
        default: begin
            tlb_model[random_m] = entry_from_regs();
            random_m            = random_m - 1'b1;
        end
    endcase
endfunction

function automatic xlate_rsp_t expected_xlate(xlate_req_t r, bit dirty_check);
    xlate_rsp_t exp;
    tlb_page_t  pg;
    int         hit;
    exp = '0;
    if (r.vaddr >= `KSEG0_BASE && r.vaddr < `KSEG1_BASE) begin
        exp.paddr = r.vaddr - `KSEG0_BASE;
    end else if (r.vaddr >= `KSEG1_BASE && r.vaddr < 32'hC000_0000) begin
        exp.paddr    = r.vaddr - `KSEG1_BASE;
        exp.uncached = 1'b1;
    end else begin
        hit = find_match(r.vaddr[31:13], hi_m.asid);
        if (hit < 0) begin
            exp.miss = 1'b1;
        end else begin
            pg           = r.vaddr[12] ? tlb_model[hit].odd : tlb_model[hit].even;
            exp.paddr    = {pg.pfn, r.vaddr[11:0]};
            exp.invalid  = !pg.v;
            exp.modified = dirty_check && r.is_store && pg.v && !pg.d;
            exp.uncached = (pg.c != `CACHED_ATTR);
        end
    end
    return exp;
endfunction

`endif

/* sim/tb_tlb_mmu.sv */
`timescale 1ns/1ps
`include "mmu_defines.svh"

module tb_tlb_mmu;
    import mmu_pkg::*;

    localparam int rounds    = 20;
    localparam int burst_len = 12;
    // cp0 accesses and commands of one round, plus its translations
    localparam int ops_per_round   = 24 + 4 * burst_len;
    localparam int total_ops       = 16 + 2 * burst_len + rounds * ops_per_round;
    localparam int watchdog_cycles = 20 * total_ops + 10;

    logic        aclk = 1'b0;
    logic        rst;
    cp0_wr_t     cp0_wr;
    logic [4:0]  cp0_raddr;
    logic [31:0] cp0_rdata;
    logic        cmd_valid;
    tlb_cmd_e    cmd_op;
    logic        cmd_ready;
    logic        ifetch_req_valid;
    xlate_req_t  ifetch_req;
    logic        ifetch_req_ready;
    logic        ifetch_rsp_valid;
    xlate_rsp_t  ifetch_rsp;
    logic        ifetch_rsp_ready;
    logic        data_req_valid;
    xlate_req_t  data_req;
    logic        data_req_ready;
    logic        data_rsp_valid;
    xlate_rsp_t  data_rsp;
    logic        data_rsp_ready;

    integer             seed = 32'hf72d;
    int                 n_errors = 0;
    int                 n_rsp = 0;
    // page pair most recently written, so bursts hit it often
    logic [`VPN2_W-1:0] focus_vpn2 = 19'h10;

    always #5 aclk = ~aclk;

    tlb_mmu_top i_dut (
        .aclk             (aclk),
        .rst              (rst),
        .cp0_wr           (cp0_wr),
        .cp0_raddr        (cp0_raddr),
        .cp0_rdata        (cp0_rdata),
        .cmd_valid        (cmd_valid),
        .cmd_op           (cmd_op),
        .cmd_ready        (cmd_ready),
        .ifetch_req_valid (ifetch_req_valid),
        .ifetch_req       (ifetch_req),
        .ifetch_req_ready (ifetch_req_ready),
        .ifetch_rsp_valid (ifetch_rsp_valid),
        .ifetch_rsp       (ifetch_rsp),
        .ifetch_rsp_ready (ifetch_rsp_ready),
        .data_req_valid   (data_req_valid),
        .data_req         (data_req),
        .data_req_ready   (data_req_ready),
        .data_rsp_valid   (data_rsp_valid),
        .data_rsp         (data_rsp),
        .data_rsp_ready   (data_rsp_ready)
    );

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    `include "tlb_mmu_model.svh"

    function automatic void report_mismatch(string name, logic [31:0] exp, logic [31:0] got);
        n_errors++;
        $display("Fail %s: expected %0h, got %0h", name, exp, got);
    endfunction

    function automatic void report_problem(string msg);
        n_errors++;
        $display("Error: %s", msg);
    endfunction

    function automatic void compare_rsp(string port, xlate_rsp_t exp, xlate_rsp_t got);
        n_rsp++;
        if (got.paddr !== exp.paddr)
            report_mismatch({port, "_rsp.paddr"}, exp.paddr, got.paddr);
        if (got.miss !== exp.miss)
            report_mismatch({port, "_rsp.miss"}, exp.miss, got.miss);
        if (got.invalid !== exp.invalid)
            report_mismatch({port, "_rsp.invalid"}, exp.invalid, got.invalid);
        if (got.modified !== exp.modified)
            report_mismatch({port, "_rsp.modified"}, exp.modified, got.modified);
        if (got.uncached !== exp.uncached)
            report_mismatch({port, "_rsp.uncached"}, exp.uncached, got.uncached);
    endfunction

    // kseg0, kseg1, kseg2/3, pool pages and the focus page
    function automatic logic [31:0] rand_vaddr();
        logic [31:0] r;
        logic [31:0] sel;
        r   = next_random();
        sel = next_random() % 8;
        case (sel)
            0, 1:    return `KSEG0_BASE + {3'b000, r[28:0]};
            2:       return `KSEG1_BASE + {3'b000, r[28:0]};
            3:       return {2'b11, r[29:0]};
            4, 5:    return {19'h10 + 19'(next_random() % 32), r[12:0]};
            default: return {focus_vpn2, r[12:0]};
        endcase
    endfunction

    task automatic cp0_write(input logic [4:0] reg_num, input cp0_word_u word);
        @(posedge aclk);
        cp0_wr <= '{valid: 1'b1, addr: reg_num, data: word};
        @(posedge aclk);
        cp0_wr.valid <= 1'b0;
        apply_cp0_write(reg_num, word);
    endtask

    task automatic check_cp0(input logic [4:0] reg_num, input string name);
        logic [31:0] exp;
        @(posedge aclk);
        cp0_raddr <= reg_num;
        @(negedge aclk);
        exp = expected_cp0_read(reg_num);
        if (cp0_rdata !== exp)
            report_mismatch(name, exp, cp0_rdata);
    endtask

    task automatic run_cmd(input tlb_cmd_e op);
        @(posedge aclk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        @(negedge aclk);
        while (!cmd_ready) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        cmd_valid <= 1'b0;
        apply_cmd(op);
    endtask

    // EntryHi and both EntryLo with random fields, junk in the zero bits
    task automatic stage_entry(input int target);
        cp0_word_u hi_w;
        cp0_word_u lo_w;
        hi_w         = next_random();
        hi_w.hi.vpn2 = free_vpn2(target);
        hi_w.hi.asid = 8'(next_random() % 4);
        focus_vpn2   = hi_w.hi.vpn2;
        cp0_write(`CP0_ENTRYHI, hi_w);
        lo_w = next_random();
        if (next_random() % 2 != 0)
            lo_w.lo.c = `CACHED_ATTR;
        cp0_write(`CP0_ENTRYLO0, lo_w);
        lo_w = next_random();
        if (next_random() % 2 != 0)
            lo_w.lo.c = `CACHED_ATTR;
        cp0_write(`CP0_ENTRYLO1, lo_w);
    endtask

    // n requests per port with random back-pressure, checked in order
    task automatic xlate_burst(input int n);
        xlate_rsp_t exp_if[$];
        xlate_rsp_t exp_d[$];
        int         if_sent;
        int         d_sent;
        int         cycles;
        logic       if_fire;
        logic       d_fire;
        if_sent = 0;
        d_sent  = 0;
        cycles  = 0;
        if_fire = 1'b0;
        d_fire  = 1'b0;
        while (if_sent < n || d_sent < n || exp_if.size() > 0 || exp_d.size() > 0) begin
            @(posedge aclk);
            if (!ifetch_req_valid || if_fire) begin
                ifetch_req_valid <= (if_sent < n) && (next_random() % 4 != 0);
                ifetch_req       <= '{vaddr: rand_vaddr(), is_store: 1'(next_random() % 2)};
            end
            if (!data_req_valid || d_fire) begin
                data_req_valid <= (d_sent < n) && (next_random() % 4 != 0);
                data_req       <= '{vaddr: rand_vaddr(), is_store: 1'(next_random() % 2)};
            end
            ifetch_rsp_ready <= (next_random() % 3 != 0);
            data_rsp_ready   <= (next_random() % 3 != 0);
            @(negedge aclk);
            // response due one cycle after accept
            if (if_fire && !ifetch_rsp_valid)
                report_problem("no ifetch response one cycle after accept");
            if (d_fire && !data_rsp_valid)
                report_problem("no data response one cycle after accept");
            if (ifetch_rsp_valid && ifetch_rsp_ready) begin
                if (exp_if.size() == 0)
                    report_problem("ifetch response with no request outstanding");
                else
                    compare_rsp("ifetch", exp_if.pop_front(), ifetch_rsp);
            end
            if (data_rsp_valid && data_rsp_ready) begin
                if (exp_d.size() == 0)
                    report_problem("data response with no request outstanding");
                else
                    compare_rsp("data", exp_d.pop_front(), data_rsp);
            end
            if_fire = ifetch_req_valid && ifetch_req_ready;
            d_fire  = data_req_valid && data_req_ready;
            if (if_fire) begin
                exp_if.push_back(expected_xlate(ifetch_req, 1'b0));
                if_sent++;
            end
            if (d_fire) begin
                exp_d.push_back(expected_xlate(data_req, 1'b1));
                d_sent++;
            end
            cycles++;
            if (cycles > 20 * n) begin
                report_problem("translation burst stalled, responses missing");
                break;
            end
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge aclk);
        $display("Error: watchdog expired before the test sequence finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int          idx;
        logic [31:0] word;
        rst              = 1'b1;
        cp0_wr           = '0;
        cp0_raddr        = '0;
        cmd_valid        = 1'b0;
        cmd_op           = probe;
        ifetch_req_valid = 1'b0;
        ifetch_req       = '0;
        ifetch_rsp_ready = 1'b0;
        data_req_valid   = 1'b0;
        data_req         = '0;
        data_rsp_ready   = 1'b0;
        reset_model();
        repeat (10) @(posedge aclk);
        rst <= 1'b0;

        // reset state of registers and ports
        repeat (3) begin
            @(negedge aclk);
            if (ifetch_rsp_valid !== 1'b0)
                report_mismatch("ifetch_rsp_valid", 0, ifetch_rsp_valid);
            if (data_rsp_valid !== 1'b0)
                report_mismatch("data_rsp_valid", 0, data_rsp_valid);
        end
        check_cp0(`CP0_INDEX, "index");
        check_cp0(`CP0_RANDOM, "random");
        check_cp0(`CP0_ENTRYLO0, "entry_lo0");
        check_cp0(`CP0_ENTRYLO1, "entry_lo1");
        check_cp0(`CP0_ENTRYHI, "entry_hi");
        xlate_burst(burst_len);

        for (int r = 0; r < rounds; r++) begin
            // tlbwi at a random index, upper Index bits are junk
            idx       = next_random() % `TLB_ENTRIES;
            word      = next_random();
            word[3:0] = 4'(idx);
            cp0_write(`CP0_INDEX, word);
            stage_entry(idx);
            run_cmd(write_indexed);
            xlate_burst(burst_len);

            // tlbr must overwrite stale EntryHi and EntryLo values
            cp0_write(`CP0_ENTRYHI, next_random());
            cp0_write(`CP0_ENTRYLO0, next_random());
            cp0_write(`CP0_ENTRYLO1, next_random());
            cp0_write(`CP0_INDEX, 32'(idx));
            run_cmd(read);
            check_cp0(`CP0_ENTRYHI, "entry_hi");
            check_cp0(`CP0_ENTRYLO0, "entry_lo0");
            check_cp0(`CP0_ENTRYLO1, "entry_lo1");

            // tlbp of the entry just read back, then of an absent page
            cp0_write(`CP0_INDEX, 32'((idx + 5) % `TLB_ENTRIES));
            run_cmd(probe);
            check_cp0(`CP0_INDEX, "index");
            cp0_write(`CP0_ENTRYHI, {19'h5, 5'b0, 8'(next_random() % 4)});
            run_cmd(probe);
            check_cp0(`CP0_INDEX, "index");

            // tlbwr at Random, then Random steps down
            stage_entry(random_m);
            run_cmd(write_random);
            check_cp0(`CP0_RANDOM, "random");
            xlate_burst(burst_len);
        end

        $display("%0d translation responses checked, %0d errors", n_rsp, n_errors);
        if (n_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hw
+incdir+sim
hw/mmu_pkg.sv
hw/tlb_match.sv
hw/tlb_entry_array.sv
hw/mmu_cp0.sv
hw/tlb_translate.sv
hw/tlb_mmu_top.sv
sim/tb_tlb_mmu.sv
